/* all.f */
+incdir+.
ex_pkg.sv
alu.sv
mult.sv
ex_stage.sv
regfile.sv
ex_top.sv
ex_properties.sv
ex_tb.sv

/* alu.sv */
// ALU: add/sub with halfword vector mode, logic, shifts, set-less-than, branch compares
`include "ex_consts.svh"

module alu
  import ex_pkg::*;
(
  input  alu_op_e             operator_i,
  input  operand_u            operand_a_i,
  input  operand_u            operand_b_i,
  input  logic                vector_mode_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                flag_o
);

  localparam int HALF_W  = `EX_XLEN / 2;
  localparam int SHAMT_W = $clog2(`EX_XLEN);

  // Scalar adder and subtractor
  logic [`EX_XLEN-1:0] sum_word;
  logic [`EX_XLEN-1:0] diff_word;

  // Per-lane results, no carry crosses the lane boundary
  logic [HALF_W-1:0] sum_hi;
  logic [HALF_W-1:0] sum_lo;
  logic [HALF_W-1:0] diff_hi;
  logic [HALF_W-1:0] diff_lo;

  logic [SHAMT_W-1:0] shamt;

  // Comparator outputs
  logic is_eq;
  logic is_lt_s;
  logic is_lt_u;

  ////////////////////////////////////////////////////////////
  // Adders
  ////////////////////////////////////////////////////////////

  assign sum_word  = operand_a_i.word + operand_b_i.word;
  assign diff_word = operand_a_i.word - operand_b_i.word;

  assign sum_hi  = operand_a_i.lanes.hi + operand_b_i.lanes.hi;
  assign sum_lo  = operand_a_i.lanes.lo + operand_b_i.lanes.lo;
  assign diff_hi = operand_a_i.lanes.hi - operand_b_i.lanes.hi;
  assign diff_lo = operand_a_i.lanes.lo - operand_b_i.lanes.lo;

  // Shift amount from the low bits of b
  assign shamt = operand_b_i.word[SHAMT_W-1:0];

  // Compares always work on the whole word
  assign is_eq   = (operand_a_i.word == operand_b_i.word);
  assign is_lt_s = ($signed(operand_a_i.word) < $signed(operand_b_i.word));
  assign is_lt_u = (operand_a_i.word < operand_b_i.word);

  ////////////////////////////////////////////////////////////
  // Branch flag
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (operator_i)
      ALU_EQ:  flag_o = is_eq;
      ALU_NE:  flag_o = ~is_eq;
      ALU_LT:  flag_o = is_lt_s;
      ALU_GE:  flag_o = ~is_lt_s;
      default: flag_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o = '0;
    case (operator_i)
      // Vector mode only changes add and subtract
      ALU_ADD:  result_o = vector_mode_i ? {sum_hi, sum_lo} : sum_word;
      ALU_SUB:  result_o = vector_mode_i ? {diff_hi, diff_lo} : diff_word;
      ALU_AND:  result_o = operand_a_i.word & operand_b_i.word;
      ALU_OR:   result_o = operand_a_i.word | operand_b_i.word;
      ALU_XOR:  result_o = operand_a_i.word ^ operand_b_i.word;
      ALU_SLL:  result_o = operand_a_i.word << shamt;
      ALU_SRL:  result_o = operand_a_i.word >> shamt;
      ALU_SRA:  result_o = $signed(operand_a_i.word) >>> shamt;
      // Set-less-than lands in bit 0
      ALU_SLT:  result_o[0] = is_lt_s;
      ALU_SLTU: result_o[0] = is_lt_u;
      // Branch compares also expose the flag in bit 0
      ALU_EQ,
      ALU_NE,
      ALU_LT,
      ALU_GE:   result_o[0] = flag_o;
      default:  result_o = '0;
    endcase
  end

endmodule

/* ex_consts.svh */
// Width and size macros for the execute subsystem
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath word width
`define EX_XLEN 32

// Register address width, enough for EX_NREGS entries
`define EX_RADDR_W 5

// Number of architectural registers, x0 included
`define EX_NREGS 32

// Encoding width of the ALU operator field
// Room for 16 operators, 14 in use
`define ALU_OP_WIDTH 4

`endif

/* ex_pkg.sv */
// Package: ALU operator enum, operand union, multiplier controls, request and write-port structs
`include "ex_consts.svh"

package ex_pkg;

  // ALU operators
  // The last four drive the branch flag
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE
  } alu_op_e;

  // One operand word, seen whole or as two halfword lanes
  typedef union packed {
    logic [`EX_XLEN-1:0] word;
    struct packed {
      logic [`EX_XLEN/2-1:0] hi;
      logic [`EX_XLEN/2-1:0] lo;
    } lanes;
  } operand_u;

  // Multiplier controls
  // sel_subword[0] picks the halfword of a, sel_subword[1] that of b
  // signed_mode[0] applies to a, signed_mode[1] to b
  typedef struct packed {
    logic       en;
    logic [1:0] sel_subword;
    logic [1:0] signed_mode;
    logic       mac_en;
  } mult_ctrl_t;

  // Request from decode into the execute stage
  typedef struct packed {
    alu_op_e                operator;
    operand_u               a;
    operand_u               b;
    operand_u               c;
    logic                   vector_mode;
    mult_ctrl_t             mult;
    logic [`EX_RADDR_W-1:0] alu_waddr;
    logic                   alu_we;
    logic [`EX_RADDR_W-1:0] wb_waddr;
    logic                   wb_we;
    logic                   csr_access;
    logic [`EX_XLEN-1:0]    csr_rdata;
  } ex_req_t;

  // One register file write
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] addr;
    logic [`EX_XLEN-1:0]    data;
  } rf_wport_t;

  // EX/WB pipeline register contents
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] addr;
  } wb_ctrl_t;

endpackage

/* ex_properties.sv */
// Concurrent assertions on the execute stage stall levels and EX/WB register
module ex_properties
  import ex_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      lsu_ready_i,
  input logic      wb_ready_i,
  input logic      ex_ready_o,
  input logic      ex_valid_o,
  input rf_wport_t alu_wport_o,
  input wb_ctrl_t  wb_ctrl_o
);

  // Ready needs both load/store and write-back
  ready_follows_levels: assert property (@(posedge clk) disable iff (!rst_n)
    ex_ready_o == (lsu_ready_i && wb_ready_i))
    else $error("ex_ready_o differs from lsu_ready_i AND wb_ready_i");

  // A stalled stage never writes through the ALU port
  no_write_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid_o |-> !alu_wport_o.we)
    else $error("ALU port write while ex_valid_o is low");

  // EX/WB register leaves reset empty
  wb_empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_ctrl_o.we)
    else $error("WB enable set in the first cycle after reset");

endmodule

bind ex_stage ex_properties ex_properties_i (.*);

/* ex_stage.sv */
// Execute stage: ALU and multiplier, result mux, branch outputs, stall levels, EX/WB register
`include "ex_consts.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // Request from decode
  input  ex_req_t             req_i,

  // Ready levels from load/store and write-back
  input  logic                lsu_ready_i,
  input  logic                wb_ready_i,

  // Forwarding port into the register file
  output rf_wport_t           alu_wport_o,

  // EX/WB register contents
  output wb_ctrl_t            wb_ctrl_o,

  // Branch outputs
  output logic [`EX_XLEN-1:0] jump_target_o,
  output logic                branch_decision_o,

  // Stall levels
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_flag;
  logic [`EX_XLEN-1:0] mult_result;
  logic                ex_valid;
  wb_ctrl_t            wb_ctrl_q;

  ////////////////////////////////////////////////////////////
  // Datapath units
  ////////////////////////////////////////////////////////////

  alu alu_i (
    .operator_i    (req_i.operator),
    .operand_a_i   (req_i.a),
    .operand_b_i   (req_i.b),
    .vector_mode_i (req_i.vector_mode),
    .result_o      (alu_result),
    .flag_o        (alu_flag)
  );

  // Operand c doubles as the accumulator
  mult mult_i (
    .ctrl_i   (req_i.mult),
    .op_a_i   (req_i.a),
    .op_b_i   (req_i.b),
    .mac_i    (req_i.c.word),
    .result_o (mult_result)
  );

  // Forwarded result, later assignments take priority
  always_comb
  begin
    alu_wport_o.data = alu_result;
    if (req_i.mult.en)
      alu_wport_o.data = mult_result;
    if (req_i.csr_access)
      alu_wport_o.data = req_i.csr_rdata;
  end

  // Write only when the stage actually moves
  assign alu_wport_o.we   = req_i.alu_we & ex_valid;
  assign alu_wport_o.addr = req_i.alu_waddr;

  // Branch target comes precomputed in operand c
  assign branch_decision_o = alu_flag;
  assign jump_target_o     = req_i.c.word;

  ////////////////////////////////////////////////////////////
  // Stall levels and EX/WB register
  ////////////////////////////////////////////////////////////

  assign ex_ready_o = lsu_ready_i & wb_ready_i;
  assign ex_valid   = ex_ready_o;
  assign ex_valid_o = ex_valid;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ctrl_q <= '0;
    end
    else if (ex_valid)
    begin
      wb_ctrl_q.we   <= req_i.wb_we;
      wb_ctrl_q.addr <= req_i.wb_waddr;
    end
    else if (wb_ready_i)
    begin
      // WB drained with nothing new behind it
      wb_ctrl_q.we <= 1'b0;
    end
  end

  assign wb_ctrl_o = wb_ctrl_q;

endmodule

/* ex_tb.sv */
// Testbench for ex_top: directed table, seeded random tail, value checks, watchdog, verdict
`include "ex_consts.svh"

module ex_tb
  import ex_pkg::*;
();

  // One table row, stimulus first, then expected values
  // ctl is {vector, csr, mult en, subword[1:0], signed[1:0], mac}
  // alu_w and wb_w are {we, addr[4:0]}, rdy is {lsu, wb}
  typedef struct packed {
    alu_op_e             op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] c;
    int                  ctl;
    int                  alu_w;
    int                  wb_w;
    int                  rdy;
    logic [`EX_XLEN-1:0] rdata;
    logic [`EX_XLEN-1:0] exp_data;
    int                  exp_br;
    int                  raddr;
    logic [`EX_XLEN-1:0] exp_rd;
  } row_t;

  localparam int N_DIR  = 40;
  localparam int N_RND  = 16;
  localparam int N_ROWS = N_DIR + N_RND;

  localparam row_t DIRECTED [N_DIR] = '{
    // Scalar writes, then halfword lanes with no carry across
    '{ALU_ADD, 'h5, 'h7, 'h0, 'h00, 'h21, 'h00, 3, 'h0, 'hc, 0, 0, 'h0},
    '{ALU_SUB, 'h3, 'h5, 'h0, 'h00, 'h22, 'h00, 3, 'h0, 'hfffffffe, 0, 1, 'hc},
    '{ALU_ADD, 'h0001ffff, 'h00010001, 'h0, 'h80, 'h00, 'h00, 3, 'h0, 'h00020000, 0, 2, 'hfffffffe},
    '{ALU_SUB, 'h00050000, 'h00010001, 'h0, 'h80, 'h00, 'h00, 3, 'h0, 'h0004ffff, 0, 0, 'h0},
    // Logic, shifts and set-less-than
    '{ALU_AND, 'hf0f0ff00, 'h0ff0f0f0, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'h00f0f000, 0, 0, 'h0},
    '{ALU_OR, 'hf0f0ff00, 'h0ff0f0f0, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'hfff0fff0, 0, 0, 'h0},
    '{ALU_XOR, 'hf0f0ff00, 'h0ff0f0f0, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'hff000ff0, 0, 0, 'h0},
    '{ALU_SLL, 'h3, 'h4, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'h30, 0, 0, 'h0},
    '{ALU_SRL, 'h80000000, 'h4, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'h08000000, 0, 0, 'h0},
    '{ALU_SRA, 'h80000000, 'h4, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'hf8000000, 0, 0, 'h0},
    '{ALU_SLT, 'hfffffffe, 'h1, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'h1, 0, 0, 'h0},
    '{ALU_SLTU, 'hfffffffe, 'h1, 'h0, 'h00, 'h00, 'h00, 3, 'h0, 'h0, 0, 0, 'h0},
    // Branches, taken and not taken
    '{ALU_EQ, 'h7, 'h7, 'h100, 'h00, 'h00, 'h00, 3, 'h0, 'h1, 1, 0, 'h0},
    '{ALU_NE, 'h7, 'h7, 'h104, 'h00, 'h00, 'h00, 3, 'h0, 'h0, 0, 0, 'h0},
    '{ALU_LT, 'hfffffffe, 'h1, 'h108, 'h00, 'h00, 'h00, 3, 'h0, 'h1, 1, 0, 'h0},
    '{ALU_GE, 'hfffffffe, 'h1, 'h10c, 'h00, 'h00, 'h00, 3, 'h0, 'h0, 0, 0, 'h0},
    '{ALU_NE, 'h1, 'h2, 'h110, 'h00, 'h00, 'h00, 3, 'h0, 'h1, 1, 0, 'h0},
    '{ALU_GE, 'h5, 'h5, 'h114, 'h00, 'h00, 'h00, 3, 'h0, 'h1, 1, 0, 'h0},
    '{ALU_EQ, 'h1, 'h2, 'h118, 'h00, 'h00, 'h00, 3, 'h0, 'h0, 0, 0, 'h0},
    '{ALU_LT, 'h1, 'hfffffffe, 'h11c, 'h00, 'h00, 'h00, 3, 'h0, 'h0, 0, 0, 'h0},
    // Multiplier over ALU, halfword signed modes, subword selects, MAC
    '{ALU_ADD, 'h3, 'h4, 'h0, 'h20, 'h23, 'h00, 3, 'h0, 'hc, 0, 0, 'h0},
    '{ALU_ADD, 'hffff0000, 'h0000ffff, 'h0, 'h28, 'h00, 'h00, 3, 'h0, 'hfffe0001, 0, 3, 'hc},
    '{ALU_ADD, 'hffff0000, 'h0000ffff, 'h0, 'h2e, 'h00, 'h00, 3, 'h0, 'h1, 0, 0, 'h0},
    '{ALU_ADD, 'hffff0000, 'h0000ffff, 'h0, 'h2a, 'h00, 'h00, 3, 'h0, 'hffff0001, 0, 0, 'h0},
    '{ALU_ADD, 'h00030002, 'h00070005, 'h0, 'h30, 'h00, 'h00, 3, 'h0, 'he, 0, 0, 'h0},
    '{ALU_ADD, 'h00030002, 'h00070005, 'h0, 'h38, 'h00, 'h00, 3, 'h0, 'h15, 0, 0, 'h0},
    '{ALU_ADD, 'h00030002, 'h00070005, 'h0, 'h20, 'h00, 'h00, 3, 'h0, 'h001d000a, 0, 0, 'h0},
    '{ALU_ADD, 'h3, 'h4, 'h100, 'h21, 'h23, 'h00, 3, 'h0, 'h10c, 0, 0, 'h0},
    // CSR data wins over the multiplier, x0 ignores writes
    '{ALU_ADD, 'h3, 'h4, 'hcafe0001, 'h60, 'h24, 'h00, 3, 'h0, 'hcafe0001, 0, 3, 'h10c},
    '{ALU_ADD, 'h1, 'h1, 'h0, 'h00, 'h20, 'h00, 3, 'h0, 'h2, 0, 4, 'hcafe0001},
    // Load data lands one cycle after the EX/WB load, WB beats ALU on x6
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h25, 3, 'h0, 'h0, 0, 0, 'h0},
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h00, 3, 'h12345678, 'h0, 0, 5, 'h0},
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h26, 3, 'h0, 'h0, 0, 5, 'h12345678},
    '{ALU_ADD, 'h1, 'h1, 'h0, 'h00, 'h26, 'h00, 3, 'hbbbb0000, 'h2, 0, 5, 'h12345678},
    // Back-pressure holds the pending x7 write and blocks ALU writes
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h27, 3, 'h0, 'h0, 0, 6, 'hbbbb0000},
    '{ALU_ADD, 'h1, 'h1, 'h0, 'h00, 'h28, 'h00, 2, 'hbad00007, 'h2, 0, 6, 'hbbbb0000},
    '{ALU_ADD, 'h1, 'h1, 'h0, 'h00, 'h28, 'h00, 0, 'hbad00007, 'h2, 0, 7, 'h0},
    '{ALU_ADD, 'h1, 'h1, 'h0, 'h00, 'h29, 'h00, 1, 'h77770007, 'h2, 0, 8, 'h0},
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h00, 3, 'hdead0000, 'h0, 0, 7, 'h77770007},
    '{ALU_ADD, 'h0, 'h0, 'h0, 'h00, 'h00, 'h00, 3, 'hdead0000, 'h0, 0, 9, 'h0}
  };

  logic                   clk;
  logic                   rst_n;
  ex_req_t                req;
  logic                   lsu_ready;
  logic                   wb_ready;
  logic [`EX_XLEN-1:0]    wb_rdata;
  logic [`EX_RADDR_W-1:0] rf_raddr;
  logic [`EX_XLEN-1:0]    rf_rdata;
  rf_wport_t              alu_wport;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   branch_decision;
  logic                   ex_ready;
  int                     seed = 'h8b34;
  int                     errors = 0;
  int                     checks = 0;
  int                     row_idx = 0;

  ex_top DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req),
    .lsu_ready_i       (lsu_ready),
    .wb_ready_i        (wb_ready),
    .wb_rdata_i        (wb_rdata),
    .rf_raddr_i        (rf_raddr),
    .rf_rdata_o        (rf_rdata),
    .alu_wport_o       (alu_wport),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .ex_ready_o        (ex_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected ALU result from the operator definitions
  function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b, logic vec);
    case (op)
      ALU_ADD:  return vec ? {a[31:16] + b[31:16], a[15:0] + b[15:0]} : a + b;
      ALU_SUB:  return vec ? {a[31:16] - b[31:16], a[15:0] - b[15:0]} : a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_EQ:   return {31'b0, a == b};
      ALU_NE:   return {31'b0, a != b};
      ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
      ALU_GE:   return {31'b0, $signed(a) >= $signed(b)};
      default:  return 32'h0;
    endcase
  endfunction

  // Random ALU row, no writes, reads back x7 which must stay put
  function automatic row_t random_row();
    row_t row;
    int   op_sel;
    row          = '0;
    op_sel       = $unsigned($random(seed)) % 14;
    row.op       = alu_op_e'(op_sel[3:0]);
    row.a        = $random(seed);
    row.b        = $random(seed);
    row.c        = $random(seed);
    row.ctl      = ($random(seed) & 1) << 7;
    row.rdy      = 3;
    row.exp_data = ref_alu(row.op, row.a, row.b, row.ctl[7]);
    if (row.op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE})
      row.exp_br = {31'b0, row.exp_data[0]};
    row.raddr    = 7;
    row.exp_rd   = 'h77770007;
    return row;
  endfunction

  function automatic ex_req_t to_req(row_t row);
    ex_req_t r;
    r             = '0;
    r.operator    = row.op;
    r.a.word      = row.a;
    r.b.word      = row.b;
    r.c.word      = row.c;
    r.vector_mode = row.ctl[7];
    r.csr_access  = row.ctl[6];
    r.mult        = row.ctl[5:0];
    r.alu_we      = row.alu_w[5];
    r.alu_waddr   = row.alu_w[4:0];
    r.wb_we       = row.wb_w[5];
    r.wb_waddr    = row.wb_w[4:0];
    // CSR read data rides on operand c
    r.csr_rdata   = row.c;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("ERR %s got %h expected %h at row %0d", name, got, expected, row_idx);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    #((N_ROWS + 4 + 20) * 100);
    $display("Timeout: the table did not finish in the expected number of cycles");
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus loop
  ////////////////////////////////////////////////////////////

  initial
  begin
    row_t row;
    rst_n     = 1'b0;
    req       = '0;
    lsu_ready = 1'b1;
    wb_ready  = 1'b1;
    wb_rdata  = '0;
    rf_raddr  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_ROWS; i++)
    begin
      row     = (i < N_DIR) ? DIRECTED[i] : random_row();
      row_idx = i;
      @(posedge clk);
      req       <= to_req(row);
      lsu_ready <= row.rdy[1];
      wb_ready  <= row.rdy[0];
      wb_rdata  <= row.rdata;
      rf_raddr  <= row.raddr[4:0];
      // Outputs settle well before the falling edge
      @(negedge clk);
      check_value("alu_wport_o.data", alu_wport.data, row.exp_data);
      check_value("branch_decision_o", {31'b0, branch_decision}, row.exp_br);
      check_value("jump_target_o", jump_target, row.c);
      check_value("ex_ready_o", {31'b0, ex_ready}, {31'b0, row.rdy[1] & row.rdy[0]});
      check_value("alu_wport_o.we", {31'b0, alu_wport.we},
                  {31'b0, row.alu_w[5] & row.rdy[1] & row.rdy[0]});
      check_value("alu_wport_o.addr", {27'b0, alu_wport.addr}, {27'b0, row.alu_w[4:0]});
      check_value("rf_rdata_o", rf_rdata, row.exp_rd);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* ex_top.sv */
// Top level: execute stage and register file
`include "ex_consts.svh"

module ex_top
  import ex_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  // Request from decode
  input  ex_req_t                req_i,

  // Ready levels and load data
  input  logic                   lsu_ready_i,
  input  logic                   wb_ready_i,
  input  logic [`EX_XLEN-1:0]    wb_rdata_i,

  // Register file read port
  input  logic [`EX_RADDR_W-1:0] rf_raddr_i,
  output logic [`EX_XLEN-1:0]    rf_rdata_o,

  // Stage outputs
  output rf_wport_t              alu_wport_o,
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  output logic                   ex_ready_o
);

  wb_ctrl_t  wb_ctrl;
  rf_wport_t wb_wport;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready_i),
    .alu_wport_o       (alu_wport_o),
    .wb_ctrl_o         (wb_ctrl),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        ()
  );

  // Load data joins the registered WB address and enable
  // A pending write retires only while write-back is ready
  assign wb_wport.we   = wb_ctrl.we & wb_ready_i;
  assign wb_wport.addr = wb_ctrl.addr;
  assign wb_wport.data = wb_rdata_i;

  regfile regfile_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .alu_wport_i (alu_wport_o),
    .wb_wport_i  (wb_wport),
    .raddr_i     (rf_raddr_i),
    .rdata_o     (rf_rdata_o)
  );

endmodule

/* mult.sv */
// Multiplier: signed/unsigned operands, halfword subword select, multiply-accumulate
`include "ex_consts.svh"

module mult
  import ex_pkg::*;
(
  input  mult_ctrl_t          ctrl_i,
  input  operand_u            op_a_i,
  input  operand_u            op_b_i,
  input  logic [`EX_XLEN-1:0] mac_i,
  output logic [`EX_XLEN-1:0] result_o
);

  localparam int HALF_W = `EX_XLEN / 2;

  // Extend one operand to XLEN+1 bits so a single signed multiplier serves all modes
  function automatic logic [`EX_XLEN:0] extend_op(
    input operand_u op,
    input logic     use_half,
    input logic     pick_hi,
    input logic     is_signed
  );
    logic [HALF_W-1:0]  half;
    logic [`EX_XLEN:0]  ext;
    half = pick_hi ? op.lanes.hi : op.lanes.lo;
    if (use_half)
    begin
      ext = {{(`EX_XLEN-HALF_W+1){is_signed & half[HALF_W-1]}}, half};
    end
    else
    begin
      ext = {is_signed & op.word[`EX_XLEN-1], op.word};
    end
    return ext;
  endfunction

  logic                         use_half;
  logic signed [`EX_XLEN:0]     a_ext;
  logic signed [`EX_XLEN:0]     b_ext;
  logic signed [2*`EX_XLEN+1:0] prod;
  logic [`EX_XLEN-1:0]          mac_term;

  // Any nonzero select means a 16x16 product
  assign use_half = |ctrl_i.sel_subword;

  assign a_ext = extend_op(op_a_i, use_half, ctrl_i.sel_subword[0], ctrl_i.signed_mode[0]);
  assign b_ext = extend_op(op_b_i, use_half, ctrl_i.sel_subword[1], ctrl_i.signed_mode[1]);

  assign prod = a_ext * b_ext;

  // Accumulator input
  assign mac_term = ctrl_i.mac_en ? mac_i : '0;

  // Low word of the product plus accumulator, quiet when disabled
  assign result_o = ctrl_i.en ? (prod[`EX_XLEN-1:0] + mac_term) : '0;

endmodule

/* regfile.sv */
// Register file: ALU write port, WB write port, one asynchronous read port, x0 hardwired
`include "ex_consts.svh"

module regfile
  import ex_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  // Write ports
  input  rf_wport_t              alu_wport_i,
  input  rf_wport_t              wb_wport_i,

  // Read port
  input  logic [`EX_RADDR_W-1:0] raddr_i,
  output logic [`EX_XLEN-1:0]    rdata_o
);

  logic [`EX_XLEN-1:0] regs_q [`EX_NREGS];

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `EX_NREGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else
    begin
      // ALU port first
      if (alu_wport_i.we && (alu_wport_i.addr != '0))
      begin
        regs_q[alu_wport_i.addr] <= alu_wport_i.data;
      end
      // WB port last, so it wins a same-address collision
      if (wb_wport_i.we && (wb_wport_i.addr != '0))
      begin
        regs_q[wb_wport_i.addr] <= wb_wport_i.data;
      end
    end
  end

  // x0 is never written, so it reads zero
  assign rdata_o = regs_q[raddr_i];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module ex_tb -o ex_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/ex_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "Pass line missing from sim.log"
exit 1
